// ==== sim.f ====
+incdir+hw
hw/host_bus_pkg.sv
hw/loader_pkg.sv
hw/loader_csrs.sv
hw/line_fetcher.sv
hw/read_arbiter.sv
hw/load_control.sv
hw/host_loader_top.sv
tb/host_mem_model.sv
tb/tb_host_loader.sv

// ==== Bender.yml ====
package:
  name: host_loader

sources:
  - include_dirs:
      - hw
    files:
      - hw/host_bus_pkg.sv
      - hw/loader_pkg.sv
      - hw/loader_csrs.sv
      - hw/line_fetcher.sv
      - hw/read_arbiter.sv
      - hw/load_control.sv
      - hw/host_loader_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - tb/host_mem_model.sv
      - tb/tb_host_loader.sv

// ==== tb/tb_host_loader.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "loader_config.svh"

module tb_host_loader;
  import host_bus_pkg::*;
  import loader_pkg::*;

  localparam line_data_t MEM_KEY = 64'h5a5a_c3c3_0f0f_9696;

  logic clk;
  logic rst_n;
  logic mmio_wr;
  logic mmio_rd;
  mmio_addr_t mmio_addr;
  mmio_data_t mmio_wdata;
  logic mmio_rvalid;
  mmio_data_t mmio_rdata;
  req_kind_t req_kind;
  line_addr_t req_offset;
  logic rd_valid;
  line_addr_t rd_addr;
  rd_tag_t rd_tag;
  logic rd_almost_full;
  logic rsp_valid;
  rd_tag_t rsp_tag;
  line_data_t rsp_data;
  logic buffer_addr_valid;
  load_status_t load_status;
  logic [`PROGRAM_LINES*`LINE_BITS-1:0] program_image;
  logic [`WEIGHT_LINES*`LINE_BITS-1:0] weight_image;
  logic bp_arm;

  string cur_test;
  int test_errors;
  int pass_count;
  int fail_count;
  int rd_count;
  int wgt_reads;
  int status_count;
  int af_violations;
  load_status_t last_status;
  logic prev_af;
  line_addr_t base;
  line_addr_t prog_start_addr;
  line_addr_t wgt_start_addr;
  logic [`PROGRAM_LINES*`LINE_BITS-1:0] prog_snapshot;

  host_loader_top u_dut (.*);

  host_mem_model #(.MEM_KEY(MEM_KEY), .BP_CYCLES(20)) u_mem (
    .clk(clk), .rst_n(rst_n), .bp_arm(bp_arm),
    .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_tag(rd_tag),
    .rd_almost_full(rd_almost_full), .rsp_valid(rsp_valid),
    .rsp_tag(rsp_tag), .rsp_data(rsp_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // host memory holds its own line address mixed with a fixed key.
  function automatic line_data_t line_content(input line_addr_t addr);
    return line_data_t'(addr) ^ MEM_KEY;
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("Fail %s: %s expected %h actual %h", cur_test, what, exp, act);
    test_errors++;
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      pass_count++;
      $display("%s: pass", cur_test);
    end else begin
      fail_count++;
      $display("%s: fail with %0d errors", cur_test, test_errors);
    end
  endtask

  task automatic abort_run(input string what);
    $display("Timeout in %s while waiting for %s", cur_test, what);
    $display("Verification failed");
    $finish;
  endtask

  // inputs change and outputs are sampled 2 ns after the edge, after the memory model acts.
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic watch_cycle();
    line_addr_t exp_addr;
    next_cycle();
    if (rd_valid) begin
      rd_count++;
      // each read goes to its load's start address plus the tagged line index.
      exp_addr = rd_tag[`TAG_BITS-1] ? wgt_start_addr : prog_start_addr;
      exp_addr = exp_addr + line_addr_t'(rd_tag[`TAG_BITS-2:0]);
      if (rd_addr !== exp_addr) report_mismatch("rd_addr", exp_addr, rd_addr);
    end
    if (rd_valid && rd_tag[`TAG_BITS-1]) wgt_reads++;
    if (prev_af && rd_valid) af_violations++; // no grant may happen under almost-full.
    prev_af = rd_almost_full;
    if (load_status != ST_NONE) begin
      status_count++;
      last_status = load_status;
    end
  endtask

  task automatic clear_counters();
    rd_count      = 0;
    wgt_reads     = 0;
    status_count  = 0;
    af_violations = 0;
    prev_af       = 1'b0;
    last_status   = ST_NONE;
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (10) next_cycle();
    rst_n = 1'b1;
    next_cycle();
  endtask

  task automatic write_base(input line_addr_t value);
    mmio_wr    = 1'b1;
    mmio_addr  = `CSR_BUF_BASE;
    mmio_wdata = mmio_data_t'(value);
    next_cycle();
    mmio_wr = 1'b0;
    base    = value;
  endtask

  task automatic issue_load(input req_kind_t kind, input line_addr_t offset);
    if (kind == REQ_WEIGHTS) begin
      wgt_start_addr = base + offset;
    end else begin
      prog_start_addr = base + offset;
    end
    req_kind   = kind;
    req_offset = offset;
    watch_cycle();
    req_kind = REQ_NONE;
  endtask

  task automatic wait_for_status(input int limit);
    int n;
    n = 0;
    while (status_count == 0 && n < limit) begin
      watch_cycle();
      n++;
    end
    if (status_count == 0) begin
      abort_run("a load status pulse");
    end else begin
      repeat (30) watch_cycle(); // window for a second pulse or stray reads.
    end
  endtask

  task automatic check_single_status(input load_status_t expected);
    if (status_count !== 1) report_mismatch("status pulses", 1, status_count);
    if (last_status !== expected) report_mismatch("load_status", expected, last_status);
  endtask

  task automatic check_program_image(input line_addr_t offset);
    for (int i = 0; i < `PROGRAM_LINES; i++) begin
      if (program_image[i*`LINE_BITS +: `LINE_BITS] !== line_content(base + offset + i)) begin
        report_mismatch($sformatf("program line %0d", i), line_content(base + offset + i),
                        program_image[i*`LINE_BITS +: `LINE_BITS]);
      end
    end
  endtask

  task automatic csr_readback();
    start_test("csr_readback");
    apply_reset();
    if (buffer_addr_valid !== 1'b0) report_mismatch("buffer_addr_valid", 0, buffer_addr_valid);
    write_base(32'h0000_1000);
    mmio_rd   = 1'b1;
    mmio_addr = `CSR_BUF_BASE;
    next_cycle();
    mmio_rd = 1'b0;
    if (mmio_rvalid !== 1'b1) report_mismatch("mmio_rvalid", 1, mmio_rvalid);
    if (mmio_rdata !== 64'h1000) report_mismatch("mmio_rdata", 64'h1000, mmio_rdata);
    if (buffer_addr_valid !== 1'b1) report_mismatch("buffer_addr_valid", 1, buffer_addr_valid);
    finish_test();
  endtask

  task automatic program_load();
    start_test("program_load");
    clear_counters();
    issue_load(REQ_PROGRAM, 32'd16);
    wait_for_status(300);
    check_single_status(ST_PROGRAM_VALID);
    if (rd_count !== `PROGRAM_LINES) report_mismatch("read requests", `PROGRAM_LINES, rd_count);
    check_program_image(32'd16);
    prog_snapshot = program_image;
    finish_test();
  endtask

  task automatic weight_load();
    start_test("weight_load");
    clear_counters();
    issue_load(REQ_WEIGHTS, 32'd40);
    wait_for_status(300);
    check_single_status(ST_WEIGHTS_VALID);
    for (int i = 0; i < `WEIGHT_LINES; i++) begin
      if (weight_image[i*`LINE_BITS +: `LINE_BITS] !== line_content(base + 40 + i)) begin
        report_mismatch($sformatf("weight line %0d", i), line_content(base + 40 + i),
                        weight_image[i*`LINE_BITS +: `LINE_BITS]);
      end
    end
    if (program_image !== prog_snapshot) begin
      $display("Fail %s: program image changed", cur_test);
      test_errors++;
    end
    finish_test();
  endtask

  task automatic reject_without_base();
    start_test("reject_without_base");
    apply_reset();
    clear_counters();
    issue_load(REQ_PROGRAM, 32'd0);
    wait_for_status(20);
    check_single_status(ST_REJECTED);
    if (rd_count !== 0) report_mismatch("read requests", 0, rd_count);
    finish_test();
  endtask

  task automatic back_pressure();
    start_test("back_pressure");
    apply_reset();
    write_base(32'h0000_2000);
    clear_counters();
    bp_arm = 1'b1;
    issue_load(REQ_PROGRAM, 32'd8);
    wait_for_status(400);
    bp_arm = 1'b0;
    if (af_violations !== 0) report_mismatch("reads under almost-full", 0, af_violations);
    if (rd_count !== `PROGRAM_LINES) report_mismatch("read requests", `PROGRAM_LINES, rd_count);
    check_single_status(ST_PROGRAM_VALID);
    check_program_image(32'd8);
    finish_test();
  endtask

  task automatic busy_ignored();
    start_test("busy_ignored");
    clear_counters();
    issue_load(REQ_PROGRAM, 32'd24);
    repeat (3) watch_cycle();
    issue_load(REQ_WEIGHTS, 32'd4); // arrives while the program load is still running.
    wait_for_status(300);
    check_single_status(ST_PROGRAM_VALID);
    if (wgt_reads !== 0) report_mismatch("weight reads", 0, wgt_reads);
    check_program_image(32'd24);
    finish_test();
  endtask

  initial begin
    rst_n           = 1'b0;
    mmio_wr         = 1'b0;
    mmio_rd         = 1'b0;
    mmio_addr       = '0;
    mmio_wdata      = '0;
    req_kind        = REQ_NONE;
    req_offset      = '0;
    bp_arm          = 1'b0;
    base            = '0;
    prog_start_addr = '0;
    wgt_start_addr  = '0;
    pass_count      = 0;
    fail_count      = 0;
    clear_counters();
    csr_readback();
    program_load();
    weight_load();
    reject_without_base();
    back_pressure();
    busy_ignored();
    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/host_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module host_mem_model #(
  parameter host_bus_pkg::line_data_t MEM_KEY   = 64'h5a5a_c3c3_0f0f_9696,
  parameter int unsigned              BP_CYCLES = 20
) (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           bp_arm,
  input  wire                           rd_valid,
  input  wire host_bus_pkg::line_addr_t rd_addr,
  input  wire host_bus_pkg::rd_tag_t    rd_tag,
  output logic                          rd_almost_full,
  output logic                          rsp_valid,
  output host_bus_pkg::rd_tag_t         rsp_tag,
  output host_bus_pkg::line_data_t      rsp_data
);
  import host_bus_pkg::*;

  integer     seed;
  line_addr_t pend_addr[$];
  rd_tag_t    pend_tag[$];
  int         pend_due[$];
  int         cycle;
  int         bp_left;
  bit         bp_used;
  int         pick;

  initial begin
    seed           = 32'h9d0626da;
    cycle          = 0;
    bp_left        = 0;
    bp_used        = 1'b0;
    rd_almost_full = 1'b0;
    rsp_valid      = 1'b0;
    rsp_tag        = '0;
    rsp_data       = '0;
  end

  // acts 1 ns after each rising edge, so rd_valid here belongs to the cycle just started.
  always @(posedge clk) begin
    #1;
    cycle = cycle + 1;
    if (!rst_n) begin
      pend_addr.delete();
      pend_tag.delete();
      pend_due.delete();
      bp_used        = 1'b0;
      bp_left        = 0;
      rd_almost_full = 1'b0;
      rsp_valid      = 1'b0;
    end else begin
      if (rd_valid) begin
        pend_addr.push_back(rd_addr);
        pend_tag.push_back(rd_tag);
        pend_due.push_back(cycle + 1 + int'($unsigned($random(seed)) % 8));
        if (bp_arm && !bp_used) begin
          bp_used = 1'b1;
          bp_left = BP_CYCLES;
        end
      end
      rd_almost_full = (bp_left > 0);
      if (bp_left > 0) bp_left = bp_left - 1;
      pick = -1;
      for (int i = 0; i < pend_due.size(); i++) begin
        if (pick < 0 && pend_due[i] <= cycle) pick = i; // later requests may be due first.
      end
      rsp_valid = (pick >= 0);
      if (pick >= 0) begin
        rsp_tag  = pend_tag[pick];
        rsp_data = line_data_t'(pend_addr[pick]) ^ MEM_KEY;
        pend_addr.delete(pick);
        pend_tag.delete(pick);
        pend_due.delete(pick);
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/host_loader_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "loader_config.svh"

module host_loader_top (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire                               mmio_wr,
  input  wire                               mmio_rd,
  input  wire host_bus_pkg::mmio_addr_t      mmio_addr,
  input  wire host_bus_pkg::mmio_data_t      mmio_wdata,
  output logic                              mmio_rvalid,
  output host_bus_pkg::mmio_data_t          mmio_rdata,
  input  wire loader_pkg::req_kind_t         req_kind,
  input  wire host_bus_pkg::line_addr_t      req_offset,
  output logic                              rd_valid,
  output host_bus_pkg::line_addr_t          rd_addr,
  output host_bus_pkg::rd_tag_t             rd_tag,
  input  wire                               rd_almost_full,
  input  wire                               rsp_valid,
  input  wire host_bus_pkg::rd_tag_t         rsp_tag,
  input  wire host_bus_pkg::line_data_t      rsp_data,
  output logic                              buffer_addr_valid,
  output loader_pkg::load_status_t          load_status,
  output logic [`PROGRAM_LINES*`LINE_BITS-1:0] program_image,
  output logic [`WEIGHT_LINES*`LINE_BITS-1:0]  weight_image
);
  import host_bus_pkg::*;

  localparam bit PROG_SRC = 1'b0;
  localparam bit WGT_SRC  = 1'b1;

  line_addr_t buffer_base;
  line_addr_t start_addr;
  line_addr_t req_addr_p;
  line_addr_t req_addr_w;
  rd_tag_t    req_index_p;
  rd_tag_t    req_index_w;
  rd_tag_t    rsp_index;
  line_data_t rsp_data_f;
  logic       prog_start;
  logic       wgt_start;
  logic       prog_done;
  logic       wgt_done;
  logic       req_p;
  logic       req_w;
  logic       grant_p;
  logic       grant_w;
  logic       rsp_valid_p;
  logic       rsp_valid_w;

  loader_csrs u_csrs (
    .clk(clk), .rst_n(rst_n),
    .mmio_wr(mmio_wr), .mmio_rd(mmio_rd), .mmio_addr(mmio_addr), .mmio_wdata(mmio_wdata),
    .mmio_rvalid(mmio_rvalid), .mmio_rdata(mmio_rdata),
    .buffer_base(buffer_base), .buffer_addr_valid(buffer_addr_valid)
  );

  load_control u_ctrl (
    .clk(clk), .rst_n(rst_n),
    .req_kind(req_kind), .req_offset(req_offset),
    .buffer_base(buffer_base), .buffer_addr_valid(buffer_addr_valid),
    .prog_done(prog_done), .wgt_done(wgt_done),
    .prog_start(prog_start), .wgt_start(wgt_start),
    .start_addr(start_addr), .load_status(load_status)
  );

  line_fetcher #(.NUM_LINES(`PROGRAM_LINES), .SOURCE(PROG_SRC)) u_prog (
    .clk(clk), .rst_n(rst_n),
    .start(prog_start), .start_addr(start_addr),
    .grant(grant_p), .req(req_p), .req_addr(req_addr_p), .req_index(req_index_p),
    .rsp_valid(rsp_valid_p), .rsp_index(rsp_index), .rsp_data(rsp_data_f),
    .image(program_image), .done(prog_done)
  );

  line_fetcher #(.NUM_LINES(`WEIGHT_LINES), .SOURCE(WGT_SRC)) u_wgt (
    .clk(clk), .rst_n(rst_n),
    .start(wgt_start), .start_addr(start_addr),
    .grant(grant_w), .req(req_w), .req_addr(req_addr_w), .req_index(req_index_w),
    .rsp_valid(rsp_valid_w), .rsp_index(rsp_index), .rsp_data(rsp_data_f),
    .image(weight_image), .done(wgt_done)
  );

  read_arbiter #(.SRC_A(PROG_SRC), .SRC_B(WGT_SRC)) u_arb (
    .clk(clk), .rst_n(rst_n),
    .req_a(req_p), .req_addr_a(req_addr_p), .req_index_a(req_index_p), .grant_a(grant_p),
    .req_b(req_w), .req_addr_b(req_addr_w), .req_index_b(req_index_w), .grant_b(grant_w),
    .rsp_valid_a(rsp_valid_p), .rsp_valid_b(rsp_valid_w),
    .rsp_index(rsp_index), .rsp_data_out(rsp_data_f),
    .rd_almost_full(rd_almost_full),
    .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_tag(rd_tag),
    .rsp_valid(rsp_valid), .rsp_tag(rsp_tag), .rsp_data(rsp_data)
  );

endmodule

`default_nettype wire

// ==== hw/load_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module load_control (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire loader_pkg::req_kind_t    req_kind,
  input  wire host_bus_pkg::line_addr_t req_offset,
  input  wire host_bus_pkg::line_addr_t buffer_base,
  input  wire                          buffer_addr_valid,
  input  wire                          prog_done,
  input  wire                          wgt_done,
  output logic                         prog_start,
  output logic                         wgt_start,
  output host_bus_pkg::line_addr_t     start_addr,
  output loader_pkg::load_status_t     load_status
);
  import loader_pkg::*;

  // REQ_NONE means idle. Any other value is the load in flight.
  req_kind_t active;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active      <= REQ_NONE;
      prog_start  <= 1'b0;
      wgt_start   <= 1'b0;
      load_status <= ST_NONE;
    end else begin
      prog_start  <= 1'b0;
      wgt_start   <= 1'b0;
      load_status <= ST_NONE;
      case (active)
        REQ_NONE: begin
          if (req_kind != REQ_NONE) begin
            if (!buffer_addr_valid) begin
              load_status <= ST_REJECTED; // nothing is fetched without a base.
            end else begin
              active     <= req_kind;
              prog_start <= (req_kind == REQ_PROGRAM);
              wgt_start  <= (req_kind == REQ_WEIGHTS);
            end
          end
        end
        REQ_PROGRAM: begin
          if (prog_done) begin
            active      <= REQ_NONE;
            load_status <= ST_PROGRAM_VALID;
          end
        end
        REQ_WEIGHTS: begin
          if (wgt_done) begin
            active      <= REQ_NONE;
            load_status <= ST_WEIGHTS_VALID;
          end
        end
        default: active <= REQ_NONE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (active == REQ_NONE && req_kind != REQ_NONE) begin
      start_addr <= buffer_base + req_offset;
    end
  end

endmodule

`default_nettype wire

// ==== hw/read_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "loader_config.svh"

module read_arbiter #(
  parameter bit SRC_A = 1'b0,
  parameter bit SRC_B = 1'b1
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          req_a,
  input  wire host_bus_pkg::line_addr_t req_addr_a,
  input  wire host_bus_pkg::rd_tag_t    req_index_a,
  output logic                         grant_a,
  input  wire                          req_b,
  input  wire host_bus_pkg::line_addr_t req_addr_b,
  input  wire host_bus_pkg::rd_tag_t    req_index_b,
  output logic                         grant_b,
  output logic                         rsp_valid_a,
  output logic                         rsp_valid_b,
  output host_bus_pkg::rd_tag_t        rsp_index,
  output host_bus_pkg::line_data_t     rsp_data_out,
  input  wire                          rd_almost_full,
  output logic                         rd_valid,
  output host_bus_pkg::line_addr_t     rd_addr,
  output host_bus_pkg::rd_tag_t        rd_tag,
  input  wire                          rsp_valid,
  input  wire host_bus_pkg::rd_tag_t    rsp_tag,
  input  wire host_bus_pkg::line_data_t rsp_data
);

  logic last_b; // set when side b won the last contested or uncontested grant.

  assign grant_a = !rd_almost_full && req_a && (!req_b || last_b);
  assign grant_b = !rd_almost_full && req_b && (!req_a || !last_b);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
      last_b   <= 1'b0;
    end else begin
      rd_valid <= grant_a || grant_b;
      if (grant_a || grant_b) begin
        last_b <= grant_b;
      end
    end
  end

  // the source bit replaces the top of the fetcher's index.
  always_ff @(posedge clk) begin
    if (grant_a) begin
      rd_addr <= req_addr_a;
      rd_tag  <= {SRC_A, req_index_a[`TAG_BITS-2:0]};
    end else if (grant_b) begin
      rd_addr <= req_addr_b;
      rd_tag  <= {SRC_B, req_index_b[`TAG_BITS-2:0]};
    end
  end

  assign rsp_valid_a  = rsp_valid && (rsp_tag[`TAG_BITS-1] == SRC_A);
  assign rsp_valid_b  = rsp_valid && (rsp_tag[`TAG_BITS-1] == SRC_B);
  assign rsp_index    = rsp_tag; // fetchers take the low bits as the line index.
  assign rsp_data_out = rsp_data;

endmodule

`default_nettype wire

// ==== hw/line_fetcher.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "loader_config.svh"

module line_fetcher #(
  parameter int unsigned NUM_LINES = 8,
  parameter int unsigned SOURCE    = 0
) (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           start,
  input  wire host_bus_pkg::line_addr_t  start_addr,
  input  wire                           grant,
  output logic                          req,
  output host_bus_pkg::line_addr_t      req_addr,
  output host_bus_pkg::rd_tag_t         req_index,
  input  wire                           rsp_valid,
  input  wire host_bus_pkg::rd_tag_t     rsp_index,
  input  wire host_bus_pkg::line_data_t  rsp_data,
  output logic [NUM_LINES*`LINE_BITS-1:0] image,
  output logic                          done
);
  import host_bus_pkg::*;
  import loader_pkg::*;

  localparam int unsigned CNT_BITS = $clog2(NUM_LINES + 1);
  localparam int unsigned IDX_BITS = `TAG_BITS - 1;

  fetch_state_t        state;
  line_addr_t          base_addr;
  logic [CNT_BITS-1:0] sent_cnt;
  logic [CNT_BITS-1:0] recv_cnt;
  logic [IDX_BITS-1:0] rsp_line;
  logic                rsp_hit;

  // the arbiter already steers by source. The check keeps a stray response out.
  assign rsp_hit  = rsp_valid && (state == F_RUN) &&
                    (rsp_index[`TAG_BITS-1] == 1'(SOURCE));
  assign rsp_line = rsp_index[IDX_BITS-1:0];

  // req stays up with a stable address until the grant moves sent_cnt on.
  assign req       = (state == F_RUN) && (sent_cnt < CNT_BITS'(NUM_LINES));
  assign req_addr  = base_addr + line_addr_t'(sent_cnt);
  assign req_index = rd_tag_t'(sent_cnt);
  assign done      = (state == F_DONE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= F_IDLE;
      sent_cnt <= '0;
      recv_cnt <= '0;
    end else begin
      case (state)
        F_IDLE: begin
          if (start) begin
            state    <= F_RUN;
            sent_cnt <= '0;
            recv_cnt <= '0;
          end
        end
        F_RUN: begin
          if (grant && req) begin
            sent_cnt <= sent_cnt + 1'b1;
          end
          if (rsp_hit) begin
            recv_cnt <= recv_cnt + 1'b1;
            if (recv_cnt == CNT_BITS'(NUM_LINES - 1)) begin
              state <= F_DONE; // done shows in the next cycle.
            end
          end
        end
        default: state <= F_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start && state == F_IDLE) begin
      base_addr <= start_addr;
    end
  end

  // lines land at their tagged slot, whatever order they come back in.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      image <= '0;
    end else if (rsp_hit) begin
      image[rsp_line*`LINE_BITS +: `LINE_BITS] <= rsp_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/loader_csrs.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "loader_config.svh"

module loader_csrs (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          mmio_wr,
  input  wire                          mmio_rd,
  input  wire host_bus_pkg::mmio_addr_t mmio_addr,
  input  wire host_bus_pkg::mmio_data_t mmio_wdata,
  output logic                         mmio_rvalid,
  output host_bus_pkg::mmio_data_t     mmio_rdata,
  output host_bus_pkg::line_addr_t     buffer_base,
  output logic                         buffer_addr_valid
);
  import host_bus_pkg::*;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      buffer_base <= '0;
      mmio_rvalid <= 1'b0;
    end else begin
      mmio_rvalid <= mmio_rd;
      if (mmio_wr && mmio_addr == `CSR_BUF_BASE) begin
        buffer_base <= mmio_wdata[`ADDR_BITS-1:0]; // upper data bits are dropped.
      end
    end
  end

  // unknown offsets read back as zero.
  always_ff @(posedge clk) begin
    if (mmio_rd) begin
      mmio_rdata <= (mmio_addr == `CSR_BUF_BASE) ? mmio_data_t'(buffer_base) : '0;
    end
  end

  assign buffer_addr_valid = |buffer_base; // a zero base means software has not set it yet.

endmodule

`default_nettype wire

// ==== hw/loader_pkg.sv ====
`default_nettype none

package loader_pkg;

  typedef enum logic [1:0] {
    REQ_NONE    = 2'd0,
    REQ_PROGRAM = 2'd1,
    REQ_WEIGHTS = 2'd2
  } req_kind_t;

  // anything but ST_NONE is a one-cycle pulse.
  typedef enum logic [1:0] {
    ST_NONE          = 2'd0,
    ST_PROGRAM_VALID = 2'd1,
    ST_WEIGHTS_VALID = 2'd2,
    ST_REJECTED      = 2'd3
  } load_status_t;

  typedef enum logic [1:0] {
    F_IDLE = 2'd0,
    F_RUN  = 2'd1,
    F_DONE = 2'd2
  } fetch_state_t;

endpackage

`default_nettype wire

// ==== hw/host_bus_pkg.sv ====
`default_nettype none
`include "loader_config.svh"

package host_bus_pkg;

  // line addresses count whole lines and not bytes.
  typedef logic [`ADDR_BITS-1:0] line_addr_t;

  typedef logic [`LINE_BITS-1:0] line_data_t;

  // echoed unchanged by the host on the matching response.
  typedef logic [`TAG_BITS-1:0] rd_tag_t;

  typedef logic [`MMIO_ADDR_BITS-1:0] mmio_addr_t;

  typedef logic [`MMIO_DATA_BITS-1:0] mmio_data_t;

endpackage

`default_nettype wire

// ==== hw/loader_config.svh ====
`ifndef LOADER_CONFIG_SVH
`define LOADER_CONFIG_SVH

// one host line and its address, counted in lines.
`define LINE_BITS 64
`define ADDR_BITS 32

`define PROGRAM_LINES 8
`define WEIGHT_LINES 4

// top tag bit is the source fetcher. The low bits are the line index.
`define TAG_BITS 4

`define MMIO_ADDR_BITS 8
`define MMIO_DATA_BITS 64
`define CSR_BUF_BASE 8'h08

`endif
